// File: Bender.yml
package:
  name: msx_core

sources:
  - verilog/msx_bus_pkg.sv
  - verilog/msx_cfg_pkg.sv
  - verilog/msx_cpu_timing.sv
  - verilog/msx_io_regs.sv
  - verilog/msx_slot_decode.sv
  - verilog/msx_audio_mix.sv
  - verilog/msx_core.sv
  - target: test
    files:
      - testbench/msx_core_assert.sv
      - testbench/tb_msx_core.sv

// File: list.f
verilog/msx_bus_pkg.sv
verilog/msx_cfg_pkg.sv
verilog/msx_cpu_timing.sv
verilog/msx_io_regs.sv
verilog/msx_slot_decode.sv
verilog/msx_audio_mix.sv
verilog/msx_core.sv
testbench/msx_core_assert.sv
testbench/tb_msx_core.sv

// File: testbench/msx_core_assert.sv
`timescale 1ns/100ps

module msx_core_assert (
   input logic        clk,
   input logic        reset,
   input logic        wait_n,
   input logic        iorq,
   input logic        ram_ce,
   input logic [15:0] audio_l,
   input logic [15:0] ext_sound_l,
   input logic        keyclick,
   input logic        tape_in,
   input logic        tape_motor_on
);
   int unsigned fail_count = 0;
   logic [18:0] mix_in;

   // Everything the left mixer output depends on
   assign mix_in = {ext_sound_l, keyclick, tape_in, tape_motor_on};

   wait_high_after_reset: assert property (@(posedge clk) $fell(reset) |-> wait_n)
      else begin
         $error("wait_n low in the first clock after reset");
         fail_count++;
      end

   // Memory side stays quiet on I/O cycles
   no_ram_on_io: assert property (@(posedge clk) disable iff (reset) iorq |-> !ram_ce)
      else begin
         $error("ram.ce high during an I/O cycle");
         fail_count++;
      end

   // Output moves only one clock after a mixer input moved
   audio_one_clock: assert property (@(posedge clk) disable iff (reset)
         (!$stable(audio_l) && !$past(reset) && !$past(reset, 2))
         |-> ($past(mix_in) != $past(mix_in, 2)))
      else begin
         $error("audio_l changed without an input change one clock earlier");
         fail_count++;
      end

endmodule

bind msx_core msx_core_assert i_assert (
   .clk           (clk),
   .reset         (reset),
   .wait_n        (wait_n),
   .iorq          (cpu_bus.iorq),
   .ram_ce        (ram.ce),
   .audio_l       (audio_l),
   .ext_sound_l   (ext_sound_l),
   .keyclick      (keyclick),
   .tape_in       (tape_in),
   .tape_motor_on (tape_motor_on)
);

// File: testbench/msx_core_golden.txt
// Columns, 16-bit hex each: kind a b c d e. 1 IOW port data, 2 IOR port - din, 3 MW addr data ce ahi alo
// 4 MR addr ce din ahi alo, 5 WAIT speed count pulses, 6 AUD ext_l ext_r {AA,tape} audio_l audio_r
0002_00A8_0000_0000_0000_0000
0002_00AA_0000_0000_0000_0000
0002_00FC_0000_0003_0000_0000
0002_00FD_0000_0002_0000_0000
0002_00FE_0000_0001_0000_0000
0002_00FF_0000_0000_0000_0000
0001_00A8_005A_0000_0000_0000
0002_00A8_0000_005A_0000_0000
0001_00FC_0047_0000_0000_0000
0002_00FC_0000_0007_0000_0000
0001_00FD_00C5_0000_0000_0000
0002_00FD_0000_0005_0000_0000
0002_0098_0000_00FF_0000_0000
// Slot 0 ROM in pages 0-1, pages 2-3 empty
0001_00A8_0000_0000_0000_0000
0004_0123_0001_0097_0010_0123
0004_5ABC_0001_0053_0010_5ABC
0004_8000_0000_00FF_0000_0000
0004_C123_0000_00FF_0000_0000
0003_0123_0000_0000_0000_0000
0004_0123_0001_0097_0010_0123
// All pages in slot 3, mapper RAM
0001_00A8_00FF_0000_0000_0000
0003_0010_003C_0001_0001_C010
0004_0010_0001_003C_0001_C010
0004_8020_0001_0060_0000_4020
0004_4200_0001_0043_0001_4200
0001_00FF_0007_0000_0000_0000
0004_C010_0001_003C_0001_C010
0003_4100_00E1_0001_0001_4100
0001_00FE_0005_0000_0000_0000
0004_8100_0001_00E1_0001_4100
// M1 wait states
0005_0000_0002_0002_0000_0000
0005_0001_0003_0003_0000_0000
0005_0002_0001_0001_0000_0000
0005_0002_0007_0007_0000_0000
0005_0000_0000_0000_0000_0000
// Audio mix with saturation
0006_0100_FF00_0000_0200_FE00
0006_1000_F000_8001_2400_E400
0006_3F00_C000_9001_7FFF_8600
0006_8000_0000_1001_8000_0200
0006_C000_3FFF_1000_8000_7FFE

// File: testbench/tb_msx_core.sv
`timescale 1ns/100ps

module tb_msx_core;
   import msx_bus_pkg::*;
   import msx_cfg_pkg::*;

   localparam int HALF_PERIOD     = 10;
   localparam int MAPPER_SEGMENTS = 64;
   localparam int MEM_BYTES       = 1 << RAM_ADDR_BITS;
   localparam int MAX_OPS         = 128;
   localparam int TIMEOUT         = 200;

   // Golden operation kinds
   localparam logic [15:0] OP_IOW  = 16'h0001;
   localparam logic [15:0] OP_IOR  = 16'h0002;
   localparam logic [15:0] OP_MW   = 16'h0003;
   localparam logic [15:0] OP_MR   = 16'h0004;
   localparam logic [15:0] OP_WAIT = 16'h0005;
   localparam logic [15:0] OP_AUD  = 16'h0006;

   logic          clk;
   logic          reset;
   msx_config_t   cfg;
   cpu_bus_t      cpu_bus;
   logic [7:0]    cpu_din;
   logic          wait_n;
   logic          cpu_ce;
   ram_req_t      ram;
   logic [7:0]    ram_dout;
   logic          tape_in;
   logic          tape_motor_on;
   audio_sample_t ext_sound_l;
   audio_sample_t ext_sound_r;
   audio_sample_t audio_l;
   audio_sample_t audio_r;

   // External 4 MB memory and the operation list
   logic [7:0]  mem [0:MEM_BYTES-1];
   logic [95:0] golden [0:MAX_OPS-1];
   int          ops;
   int          errors;

   msx_core #(.MAPPER_SEGMENTS(MAPPER_SEGMENTS)) i_dut (
      .clk           (clk),
      .reset         (reset),
      .cfg           (cfg),
      .cpu_bus       (cpu_bus),
      .cpu_din       (cpu_din),
      .wait_n        (wait_n),
      .cpu_ce        (cpu_ce),
      .ram           (ram),
      .ram_dout      (ram_dout),
      .tape_in       (tape_in),
      .tape_motor_on (tape_motor_on),
      .ext_sound_l   (ext_sound_l),
      .ext_sound_r   (ext_sound_r),
      .audio_l       (audio_l),
      .audio_r       (audio_r)
   );

   always #HALF_PERIOD clk = ~clk;

   // Read data is combinational and writes land on the rising edge
   assign ram_dout = mem[ram.addr];

   always @(posedge clk) begin
      if (ram.ce && !ram.rnw) begin
         mem[ram.addr] <= ram.din;
      end
   end

   // Folded address bytes with the ROM window scrambled
   function automatic logic [7:0] fill_byte(logic [RAM_ADDR_BITS-1:0] addr);
      logic [7:0] value;
      value = addr[7:0] ^ addr[15:8] ^ {2'b00, addr[21:16]};
      if (addr[RAM_ADDR_BITS-1:ROM_OFFSET_BITS] == ROM_SEGMENT_BASE_BITS) begin
         value = value ^ 8'hA5;
      end
      return value;
   endfunction

   function automatic int divisor_of(logic [1:0] speed);
      case (speed)
         2'd1:    return DIV_5M39;
         2'd2:    return DIV_10M7;
         default: return DIV_3M58;
      endcase
   endfunction

   task automatic report_mismatch(input string msg);
      errors++;
      $display("** Error at %0d ns: %s", $time, msg);
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Operations: %0d, errors: %0d, assertion failures: %0d",
               ops, errors, i_dut.i_assert.fail_count);
      $display("Errors found");
      $finish;
   endtask

   // Ends at the sample point just before the rising edge
   task automatic wait_ready();
      int n;
      n = 0;
      #(HALF_PERIOD - 1);
      while (!wait_n && n < TIMEOUT) begin
         @(negedge clk);
         #(HALF_PERIOD - 1);
         n++;
      end
      if (!wait_n) begin
         abort_run("Timeout: wait_n stayed low during a bus cycle");
      end
   endtask

   task automatic start_cycle(input logic [15:0] addr, input logic [7:0] data,
                              input logic io, input logic write);
      @(negedge clk);
      cpu_bus      = '0;
      cpu_bus.addr = addr;
      cpu_bus.dout = data;
      cpu_bus.iorq = io;
      cpu_bus.mreq = !io;
      cpu_bus.wr   = write;
      cpu_bus.rd   = !write;
      wait_ready();
   endtask

   task automatic end_cycle();
      @(negedge clk);
      cpu_bus = '0;
   endtask

   task automatic io_write(input logic [7:0] port, input logic [7:0] data);
      start_cycle({8'h00, port}, data, 1'b1, 1'b1);
      end_cycle();
   endtask

   task automatic io_read(input logic [7:0] port, input logic [7:0] exp_din);
      start_cycle({8'h00, port}, 8'h00, 1'b1, 1'b0);
      if (cpu_din !== exp_din) begin
         report_mismatch($sformatf("IOR %h: cpu_din %h, expected %h", port, cpu_din, exp_din));
      end
      end_cycle();
   endtask

   task automatic mem_write(input logic [15:0] addr, input logic [7:0] data,
                            input logic exp_ce, input logic [21:0] exp_addr);
      start_cycle(addr, data, 1'b0, 1'b1);
      if (ram.ce !== exp_ce) begin
         report_mismatch($sformatf("MW %h: ram.ce %b, expected %b", addr, ram.ce, exp_ce));
      end
      if (exp_ce && (ram.addr !== exp_addr || ram.rnw !== 1'b0 || ram.din !== data)) begin
         report_mismatch($sformatf("MW %h: addr %h rnw %b din %h, expected %h rnw 0 din %h",
                                   addr, ram.addr, ram.rnw, ram.din, exp_addr, data));
      end
      end_cycle();
   endtask

   task automatic mem_read(input logic [15:0] addr, input logic exp_ce,
                           input logic [7:0] exp_din, input logic [21:0] exp_addr);
      start_cycle(addr, 8'h00, 1'b0, 1'b0);
      if (ram.ce !== exp_ce) begin
         report_mismatch($sformatf("MR %h: ram.ce %b, expected %b", addr, ram.ce, exp_ce));
      end
      if (exp_ce && ram.addr !== exp_addr) begin
         report_mismatch($sformatf("MR %h: ram.addr %h, expected %h", addr, ram.addr, exp_addr));
      end
      if (cpu_din !== exp_din) begin
         report_mismatch($sformatf("MR %h: cpu_din %h, expected %h", addr, cpu_din, exp_din));
      end
      end_cycle();
   endtask

   // Raise m1 and count CPU clocks while the CPU is held
   task automatic run_wait(input logic [1:0] speed, input logic [2:0] count,
                           input int exp_pulses);
      int div;
      int n;
      int low_clks;
      int pulses;
      div      = divisor_of(speed);
      low_clks = 0;
      pulses   = 0;
      @(negedge clk);
      cfg.cpu_speed  = cpu_speed_e'(speed);
      cfg.wait_count = count;
      @(negedge clk);
      cpu_bus.m1 = 1'b1;
      #(HALF_PERIOD - 1);
      if (count == 3'd0) begin
         // No drop expected so watch a few CPU periods
         for (n = 0; n < 4 * div; n++) begin
            if (!wait_n) begin
               low_clks++;
               if (cpu_ce) begin
                  pulses++;
               end
            end
            @(negedge clk);
            #(HALF_PERIOD - 1);
         end
      end else begin
         n = 0;
         while (wait_n && n < TIMEOUT) begin
            @(negedge clk);
            #(HALF_PERIOD - 1);
            n++;
         end
         if (wait_n) begin
            abort_run("Timeout: wait_n never went low after m1");
         end
         n = 0;
         while (!wait_n && n < TIMEOUT) begin
            low_clks++;
            if (cpu_ce) begin
               pulses++;
            end
            @(negedge clk);
            #(HALF_PERIOD - 1);
            n++;
         end
         if (!wait_n) begin
            abort_run("Timeout: wait_n never returned high");
         end
      end
      if (pulses != exp_pulses) begin
         report_mismatch($sformatf("WAIT speed %0d count %0d: %0d pulses, expected %0d",
                                   speed, count, pulses, exp_pulses));
      end
      if (count == 3'd0 && low_clks != 0) begin
         report_mismatch($sformatf("WAIT speed %0d: wait_n low with zero waits", speed));
      end
      if (count != 3'd0 && low_clks < count * div - div + 1) begin
         report_mismatch($sformatf("WAIT speed %0d count %0d: low %0d clocks, minimum %0d",
                                   speed, count, low_clks, count * div - div + 1));
      end
      @(negedge clk);
      cpu_bus.m1     = 1'b0;
      cfg.wait_count = 3'd0;
   endtask

   // Click and motor through port AA and then one clock of latency
   task automatic run_audio(input logic [15:0] left, input logic [15:0] right,
                            input logic [7:0] aa, input logic tape,
                            input logic [15:0] exp_l, input logic [15:0] exp_r);
      io_write(8'hAA, aa);
      @(negedge clk);
      ext_sound_l = left;
      ext_sound_r = right;
      tape_in     = tape;
      @(negedge clk);
      #(HALF_PERIOD - 1);
      if (audio_l !== exp_l || audio_r !== exp_r) begin
         report_mismatch($sformatf("AUD %h/%h AA %h: audio %h/%h, expected %h/%h",
                                   left, right, aa, audio_l, audio_r, exp_l, exp_r));
      end
      if (tape_motor_on !== !aa[4]) begin
         report_mismatch($sformatf("AUD AA %h: tape_motor_on %b", aa, tape_motor_on));
      end
   endtask

   initial begin
      int i;
      logic [15:0] kind;
      logic [15:0] fa;
      logic [15:0] fb;
      logic [15:0] fc;
      logic [15:0] fd;
      logic [15:0] fe;
      clk         = 1'b0;
      reset       = 1'b1;
      cfg         = '0;
      cpu_bus     = '0;
      tape_in     = 1'b0;
      ext_sound_l = '0;
      ext_sound_r = '0;
      ops         = 0;
      errors      = 0;
      for (i = 0; i < MEM_BYTES; i++) begin
         mem[i] = fill_byte(i[RAM_ADDR_BITS-1:0]);
      end
      for (i = 0; i < MAX_OPS; i++) begin
         golden[i] = '0;
      end
      $readmemh("testbench/msx_core_golden.txt", golden);
      repeat (10) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      #(HALF_PERIOD - 1);
      // Reset state with the motor on because AA bit 4 is 0
      if (wait_n !== 1'b1 || tape_motor_on !== 1'b1 || audio_l !== 16'h0 || audio_r !== 16'h0) begin
         report_mismatch("reset state of wait_n, tape_motor_on or audio is wrong");
      end
      while (ops < MAX_OPS && golden[ops][95:80] != 16'h0) begin
         {kind, fa, fb, fc, fd, fe} = golden[ops];
         case (kind)
            OP_IOW:  io_write(fa[7:0], fb[7:0]);
            OP_IOR:  io_read(fa[7:0], fc[7:0]);
            OP_MW:   mem_write(fa, fb[7:0], fc[0], {fd[5:0], fe});
            OP_MR:   mem_read(fa, fb[0], fc[7:0], {fd[5:0], fe});
            OP_WAIT: run_wait(fa[1:0], fb[2:0], int'(fc));
            OP_AUD:  run_audio(fa, fb, fc[15:8], fc[0], fd, fe);
            default: begin
               $display("Unknown operation kind %h in golden entry %0d", kind, ops);
               errors++;
            end
         endcase
         ops++;
      end
      if (ops == 0) begin
         $display("The golden file held no operations");
         errors++;
      end
      $display("Operations: %0d, errors: %0d, assertion failures: %0d",
               ops, errors, i_dut.i_assert.fail_count);
      if (errors == 0 && i_dut.i_assert.fail_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: verilog/msx_audio_mix.sv
`timescale 1ns/100ps

module msx_audio_mix (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       keyclick,
   input  logic                       tape_motor_on,
   input  logic                       tape_in,
   input  msx_cfg_pkg::audio_sample_t ext_sound_l,
   input  msx_cfg_pkg::audio_sample_t ext_sound_r,
   output msx_cfg_pkg::audio_sample_t audio_l,
   output msx_cfg_pkg::audio_sample_t audio_r
);
   import msx_cfg_pkg::*;

   logic [9:0] sys_term;

   // Add system term, double, saturate
   function automatic audio_sample_t mix_clamp(audio_sample_t sample, logic [9:0] term);
      logic signed [17:0] mix;
      mix = (18'(sample) + $signed({8'd0, term})) <<< 1;
      if (mix > 18'sd32767) begin
         mix_clamp = 16'sh7FFF;
      end else if (mix < -18'sd32768) begin
         mix_clamp = 16'sh8000;
      end else begin
         mix_clamp = mix[15:0];
      end
   endfunction

   // Click 512, tape monitor 256 only with motor off
   assign sys_term = {keyclick, tape_in & ~tape_motor_on, 8'd0};

   always_ff @(posedge clk) begin
      if (reset) begin
         audio_l <= '0;
         audio_r <= '0;
      end else begin
         audio_l <= mix_clamp(ext_sound_l, sys_term);
         audio_r <= mix_clamp(ext_sound_r, sys_term);
      end
   end

endmodule

// File: verilog/msx_bus_pkg.sv
package msx_bus_pkg;

   // External memory space, 4 MB
   localparam int RAM_ADDR_BITS    = 22;
   // Offset inside one 16 KB page
   localparam int PAGE_OFFSET_BITS = 14;
   // BIOS ROM spans pages 0 and 1, 32 KB
   localparam int ROM_OFFSET_BITS  = 15;

   // Upper address bits of the ROM window
   // 1 MB, just above 64 mapper segments of RAM
   localparam logic [RAM_ADDR_BITS-ROM_OFFSET_BITS-1:0] ROM_SEGMENT_BASE_BITS = 7'h20;

   // Z80 bus, flags already active high
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  dout;
      logic        mreq;
      logic        iorq;
      logic        rd;
      logic        wr;
      logic        m1;
   } cpu_bus_t;

   // Request to SDRAM/BRAM side
   typedef struct packed {
      logic [RAM_ADDR_BITS-1:0] addr;
      logic [7:0]               din;
      logic                     rnw;
      logic                     ce;
   } ram_req_t;

   typedef enum logic [2:0] {
      BUS_IDLE,
      BUS_MEM_RD,
      BUS_MEM_WR,
      BUS_IO_RD,
      BUS_IO_WR
   } bus_cycle_e;

endpackage

// File: verilog/msx_cfg_pkg.sv
package msx_cfg_pkg;

   // CPU clock choices
   typedef enum logic [1:0] {
      SPEED_3M58,
      SPEED_5M39,
      SPEED_10M7
   } cpu_speed_e;

   // User machine settings
   typedef struct packed {
      // Extra waits after each M1
      logic [2:0] wait_count;
      cpu_speed_e cpu_speed;
   } msx_config_t;

   // System clocks per CPU enable
   localparam int unsigned DIV_3M58 = 6;
   localparam int unsigned DIV_5M39 = 4;
   localparam int unsigned DIV_10M7 = 2;

   // Audio sample, two's complement
   typedef logic signed [15:0] audio_sample_t;

endpackage

// File: verilog/msx_core.sv
`timescale 1ns/100ps

module msx_core #(
   parameter int MAPPER_SEGMENTS = 64
) (
   input  logic                       clk,
   input  logic                       reset,
   input  msx_cfg_pkg::msx_config_t   cfg,
   // CPU side
   input  msx_bus_pkg::cpu_bus_t      cpu_bus,
   output logic [7:0]                 cpu_din,
   output logic                       wait_n,
   output logic                       cpu_ce,
   // External memory
   output msx_bus_pkg::ram_req_t      ram,
   input  logic [7:0]                 ram_dout,
   // Cassette
   input  logic                       tape_in,
   output logic                       tape_motor_on,
   // Sound
   input  msx_cfg_pkg::audio_sample_t ext_sound_l,
   input  msx_cfg_pkg::audio_sample_t ext_sound_r,
   output msx_cfg_pkg::audio_sample_t audio_l,
   output msx_cfg_pkg::audio_sample_t audio_r
);
   import msx_bus_pkg::*;

   bus_cycle_e      cycle;
   logic [7:0]      slot_config;
   logic [3:0][7:0] seg;
   logic            keyclick;
   logic [7:0]      io_data;
   logic            io_oe;

   // CPU enable and M1 waits
   msx_cpu_timing u_cpu_timing (
      .clk    (clk),
      .reset  (reset),
      .cfg    (cfg),
      .m1     (cpu_bus.m1),
      .cpu_ce (cpu_ce),
      .wait_n (wait_n)
   );

   // Ports A8, AA, FC-FF
   msx_io_regs #(.MAPPER_SEGMENTS(MAPPER_SEGMENTS)) u_io_regs (
      .clk           (clk),
      .reset         (reset),
      .cpu_bus       (cpu_bus),
      .cycle         (cycle),
      .slot_config   (slot_config),
      .seg           (seg),
      .keyclick      (keyclick),
      .tape_motor_on (tape_motor_on),
      .io_data       (io_data),
      .io_oe         (io_oe)
   );

   // Slots, memory address, read mux
   msx_slot_decode #(.MAPPER_SEGMENTS(MAPPER_SEGMENTS)) u_slot_decode (
      .cpu_bus     (cpu_bus),
      .cycle       (cycle),
      .slot_config (slot_config),
      .seg         (seg),
      .io_data     (io_data),
      .io_oe       (io_oe),
      .ram         (ram),
      .ram_dout    (ram_dout),
      .cpu_din     (cpu_din)
   );

   msx_audio_mix u_audio_mix (
      .clk           (clk),
      .reset         (reset),
      .keyclick      (keyclick),
      .tape_motor_on (tape_motor_on),
      .tape_in       (tape_in),
      .ext_sound_l   (ext_sound_l),
      .ext_sound_r   (ext_sound_r),
      .audio_l       (audio_l),
      .audio_r       (audio_r)
   );

endmodule

// File: verilog/msx_cpu_timing.sv
`timescale 1ns/100ps

module msx_cpu_timing (
   input  logic                     clk,
   input  logic                     reset,
   input  msx_cfg_pkg::msx_config_t cfg,
   input  logic                     m1,
   output logic                     cpu_ce,
   output logic                     wait_n
);
   import msx_cfg_pkg::*;

   logic [2:0] divisor;
   logic [2:0] div_cnt;
   logic       last_m1;
   logic [2:0] wait_cnt;

   // Divisor for the selected speed
   always_comb begin
      case (cfg.cpu_speed)
         SPEED_5M39: divisor = 3'(DIV_5M39);
         SPEED_10M7: divisor = 3'(DIV_10M7);
         default:    divisor = 3'(DIV_3M58);
      endcase
   end

   // Enable on last count of the period
   // >= so a speed change mid-period cannot overrun
   assign cpu_ce = (div_cnt >= divisor - 3'd1);

   always_ff @(posedge clk) begin
      if (reset) begin
         div_cnt <= 3'd0;
      end else if (cpu_ce) begin
         div_cnt <= 3'd0;
      end else begin
         div_cnt <= div_cnt + 3'd1;
      end
   end

   // M1 rising edge loads the wait counter
   always_ff @(posedge clk) begin
      if (reset) begin
         last_m1  <= 1'b0;
         wait_cnt <= 3'd0;
      end else begin
         last_m1 <= m1;
         if (m1 && !last_m1) begin
            wait_cnt <= cfg.wait_count;
         end else if (cpu_ce && wait_cnt != 3'd0) begin
            // One wait per CPU clock
            wait_cnt <= wait_cnt - 3'd1;
         end
      end
   end

   assign wait_n = (wait_cnt == 3'd0);

endmodule

// File: verilog/msx_io_regs.sv
`timescale 1ns/100ps

module msx_io_regs #(
   parameter int MAPPER_SEGMENTS = 64
) (
   input  logic                    clk,
   input  logic                    reset,
   input  msx_bus_pkg::cpu_bus_t   cpu_bus,
   output msx_bus_pkg::bus_cycle_e cycle,
   output logic [7:0]              slot_config,
   output logic [3:0][7:0]         seg,
   output logic                    keyclick,
   output logic                    tape_motor_on,
   output logic [7:0]              io_data,
   output logic                    io_oe
);
   import msx_bus_pkg::*;

   // Owned I/O ports
   localparam logic [7:0] PORT_PSL    = 8'hA8;
   localparam logic [7:0] PORT_PPI_C  = 8'hAA;
   localparam logic [7:0] PORT_MAP_FC = 8'hFC;
   localparam logic [7:0] PORT_MAP_FD = 8'hFD;
   localparam logic [7:0] PORT_MAP_FE = 8'hFE;
   localparam logic [7:0] PORT_MAP_FF = 8'hFF;

   // Only implemented segment bits are kept
   localparam logic [7:0] SEG_MASK = 8'(MAPPER_SEGMENTS - 1);

   logic       req;
   logic [7:0] port;
   logic [7:0] port_aa;

   assign req  = (cpu_bus.mreq || cpu_bus.iorq) && (cpu_bus.rd || cpu_bus.wr);
   assign port = cpu_bus.addr[7:0];

   // Cycle type, shared with slot decode
   // I/O wins if both strobes show up
   always_comb begin
      if (!req) begin
         cycle = BUS_IDLE;
      end else if (cpu_bus.iorq) begin
         cycle = cpu_bus.wr ? BUS_IO_WR : BUS_IO_RD;
      end else begin
         cycle = cpu_bus.wr ? BUS_MEM_WR : BUS_MEM_RD;
      end
   end

   // Register writes
   always_ff @(posedge clk) begin
      if (reset) begin
         slot_config <= 8'h00;
         port_aa     <= 8'h00;
         // FC=3, FD=2, FE=1, FF=0
         seg         <= {8'd0, 8'd1, 8'd2, 8'd3};
      end else if (cycle == BUS_IO_WR) begin
         case (port)
            PORT_PSL:   slot_config <= cpu_bus.dout;
            PORT_PPI_C: port_aa     <= cpu_bus.dout;
            PORT_MAP_FC, PORT_MAP_FD, PORT_MAP_FE, PORT_MAP_FF: begin
               // Low two port bits pick the page
               seg[port[1:0]] <= cpu_bus.dout & SEG_MASK;
            end
            default: ;
         endcase
      end
   end

   // Read-back path
   always_comb begin
      io_oe   = 1'b0;
      io_data = 8'hFF;
      if (cycle == BUS_IO_RD) begin
         case (port)
            PORT_PSL: begin
               io_oe   = 1'b1;
               io_data = slot_config;
            end
            PORT_PPI_C: begin
               io_oe   = 1'b1;
               io_data = port_aa;
            end
            PORT_MAP_FC, PORT_MAP_FD, PORT_MAP_FE, PORT_MAP_FF: begin
               io_oe   = 1'b1;
               io_data = seg[port[1:0]];
            end
            default: ;
         endcase
      end
   end

   // PPI port C: bit 7 click, bit 4 motor, low = on
   assign keyclick      = port_aa[7];
   assign tape_motor_on = ~port_aa[4];

endmodule

// File: verilog/msx_slot_decode.sv
`timescale 1ns/100ps

module msx_slot_decode #(
   parameter int MAPPER_SEGMENTS = 64
) (
   input  msx_bus_pkg::cpu_bus_t   cpu_bus,
   input  msx_bus_pkg::bus_cycle_e cycle,
   input  logic [7:0]              slot_config,
   input  logic [3:0][7:0]         seg,
   input  logic [7:0]              io_data,
   input  logic                    io_oe,
   output msx_bus_pkg::ram_req_t   ram,
   input  logic [7:0]              ram_dout,
   output logic [7:0]              cpu_din
);
   import msx_bus_pkg::*;

   // Segment number width
   localparam int SEG_W = $clog2(MAPPER_SEGMENTS);

   logic [1:0]               page;
   logic [1:0]               active_slot;
   logic [7:0]               seg_sel;
   logic                     mem_cycle;
   logic                     rd_cycle;
   logic                     ram_sel;
   logic                     rom_sel;
   logic [RAM_ADDR_BITS-1:0] ram_win_addr;
   logic [RAM_ADDR_BITS-1:0] rom_addr;

   assign page = cpu_bus.addr[15:14];

   // Primary slot of the addressed page
   always_comb begin
      case (page)
         2'd0:    active_slot = slot_config[1:0];
         2'd1:    active_slot = slot_config[3:2];
         2'd2:    active_slot = slot_config[5:4];
         default: active_slot = slot_config[7:6];
      endcase
   end

   assign seg_sel   = seg[page];
   assign mem_cycle = (cycle == BUS_MEM_RD) || (cycle == BUS_MEM_WR);
   assign rd_cycle  = (cycle == BUS_MEM_RD) || (cycle == BUS_IO_RD);

   // Slot 3 mapper RAM, read and write
   assign ram_sel = mem_cycle && (active_slot == 2'd3);
   // Slot 0 BIOS, pages 0-1, read only
   assign rom_sel = (cycle == BUS_MEM_RD) && (active_slot == 2'd0) && !cpu_bus.addr[15];

   // Segment times 16 KB plus page offset
   assign ram_win_addr = RAM_ADDR_BITS'({seg_sel[SEG_W-1:0],
                                         cpu_bus.addr[PAGE_OFFSET_BITS-1:0]});
   assign rom_addr     = {ROM_SEGMENT_BASE_BITS, cpu_bus.addr[ROM_OFFSET_BITS-1:0]};

   // Memory request
   assign ram.addr = (active_slot == 2'd0) ? rom_addr : ram_win_addr;
   assign ram.din  = cpu_bus.dout;
   assign ram.rnw  = (cycle != BUS_MEM_WR);
   assign ram.ce   = ram_sel || rom_sel;

   // CPU read data, by priority
   always_comb begin
      if (!rd_cycle) begin
         cpu_din = 8'hFF;
      end else if (io_oe) begin
         cpu_din = io_data;
      end else if (cycle == BUS_MEM_RD && ram.ce) begin
         cpu_din = ram_dout;
      end else begin
         // Empty slot or unowned port
         cpu_din = 8'hFF;
      end
   end

endmodule
